/* dqla_board.f */
+incdir+tests
src/board_pkg.sv
src/board_regs.sv
src/mv_settle_timer.sv
src/host_watchdog.sv
src/board_ctrl_top.sv
tests/tb_board_ctrl.sv

/* Makefile */
# Verilator build for the board control testbench

VERILATOR  = verilator
FLAGS      = --binary --timing -j 0 -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_board_ctrl
RTL_TOP    = board_ctrl_top
FILELIST   = dqla_board.f
OBJ_DIR    = obj_dir
PASS_MSG   = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_checks.svh */
// ------------------------------
// compare tasks for the board control testbench,
// LCG for random stimulus
// ------------------------------
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

logic [31:0] lcg_state = 32'h1bde_00ab;

// full-period 32-bit LCG
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// ------------------------------
// compare tasks
// ------------------------------
task automatic check_rdata(input string what, input logic [31:0] exp,
                           input logic [31:0] act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
endtask

// whole control struct, pulses and amp disables included
task automatic check_ctrl(input string what, input board_ctrl_t exp,
                          input board_ctrl_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
endtask

`endif

/* tests/tb_board_ctrl.sv */
// ------------------------------
// board control testbench: reset state, status masks,
// read mux, settle delay and host watchdog
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_board_ctrl;
    import board_pkg::*;

    localparam logic [3:0]  NUM_CHAN   = 4'd8;
    localparam logic [31:0] VERSION    = 32'h44514c41;      // "DQLA"
    localparam logic [23:0] SETTLE     = 24'd40;
    localparam int          WDOG_SHIFT = 2;
    localparam int          WDOG_TICKS = 3 << WDOG_SHIFT;   // period 3 in clocks
    // cycles per test: reset, masks, reads, settle, watchdog, then slack
    localparam int RUN_CYCLES = 30 + 100 + 220 + 200 + 120 + 200;

    logic        sysclk = 1'b0;
    logic        reset;
    host_wr_t    host_wr;
    reg_addr_t   reg_raddr;
    board_in_t   board_in;
    logic [31:0] reg_rdata;
    board_ctrl_t ctrl;

    // host-visible state of the reference model
    logic        m_relay;
    logic [1:0]  m_pwr;
    logic        m_timeout;
    logic [15:0] m_period;

    int          checks = 0;
    int          errors = 0;
    int          tests = 0;
    int          errs_at_start = 0;
    string       test_name = "none";
    logic [31:0] exp_q[$];        // expected read words, oldest first

    `include "tb_checks.svh"

    board_ctrl_top #(
        .NUM_CHAN      (NUM_CHAN),
        .VERSION       (VERSION),
        .SETTLE_CYCLES (SETTLE),
        .WDOG_SHIFT    (WDOG_SHIFT)
    ) board_ctrl_top_i (
        .sysclk    (sysclk),
        .reset     (reset),
        .host_wr   (host_wr),
        .reg_raddr (reg_raddr),
        .board_in  (board_in),
        .reg_rdata (reg_rdata),
        .ctrl      (ctrl)
    );

    always #4 sysclk = ~sysclk;   // 8 ns clock

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic logic [31:0] expected_read(input logic [3:0] offset,
            input board_in_t bi, input logic relay, input logic [1:0] pwr,
            input logic timeout, input logic [15:0] period);
        logic [31:0] w;
        w = '0;
        case (offset)
            REG_STATUS: begin
                w[31:28] = NUM_CHAN;
                w[27:24] = bi.board_id;
                w[23]    = timeout;
                w[22:21] = bi.quad_dac;
                w[19]    = bi.mv_good[0] & bi.mv_good[1];
                w[18]    = pwr[0] & pwr[1];
                w[16]    = relay;
                w[15:14] = bi.mv_good;
                w[11:10] = bi.dout_cfg_valid;
                w[9:8]   = bi.dout_cfg_bidir;
                w[7:6]   = bi.safety_fb;
                w[5:4]   = bi.mv_fb;
                w[3]     = bi.dout[31];
                w[1:0]   = bi.ioexp_present;
            end
            REG_VERSION: w = VERSION;
            REG_TEMPSNS: w = bi.temp_sense;
            REG_DIGIOUT: w = bi.dout;
            REG_DSSTAT:  w = bi.ds_status;
            REG_DIGIN:   w = {bi.dout[7:0], bi.neg_limit, bi.pos_limit, bi.home};
            REG_WDOG:    w[15:0] = period;
            default:     w = '0;          // unmapped
        endcase
        return w;
    endfunction

    // pulses are {dout_cfg, ioexp_cfg, dac_test}
    function automatic board_ctrl_t model_ctrl(input logic [2:0] pulses,
                                               input logic [1:0] amp);
        board_ctrl_t c;
        c.pwr_enable      = m_pwr;
        c.relay_on        = m_relay;
        c.dout_cfg_reset  = pulses[2];
        c.ioexp_cfg_reset = pulses[1];
        c.dac_test_reset  = pulses[0];
        c.mv_amp_disable  = amp;
        return c;
    endfunction

    // pr is {pwr_mask, pwr_val, relay_mask, relay_val}
    function automatic logic [31:0] cmd_word(input logic [2:0] pulses,
                                             input logic [3:0] pr);
        return {7'd0, pulses, 2'b00, pr, 16'd0};
    endfunction

    // compare process, one cycle after each read address
    always @(negedge sysclk) begin
        if (exp_q.size() > 0)
            check_rdata("reg_rdata", exp_q.pop_front(), reg_rdata);
    end

    // ------------------------------
    // bus helpers
    // ------------------------------
    // returns on the edge that takes the strobe
    task automatic host_write(input logic [3:0] sp, input logic [3:0] blk,
                              input logic [3:0] off, input logic [31:0] data);
        host_wr_t wr;
        wr.strobe   = 1'b1;
        wr.addr     = '{space: sp, chan: 4'd0, block: blk, offset: off};
        wr.data.raw = data;
        @(posedge sysclk);
        host_wr <= wr;
        @(posedge sysclk);
        host_wr.strobe <= 1'b0;
    endtask

    task automatic read_expect(input logic [3:0] off);
        @(posedge sysclk);
        reg_raddr <= '{space: ADDR_MAIN, chan: 4'd0, block: 4'd0, offset: off};
        @(posedge sysclk);   // capture edge
        exp_q.push_back(expected_read(off, board_in, m_relay, m_pwr, m_timeout, m_period));
    endtask

    // cycles the amp disable stays high, bounded
    task automatic settle_length(input int pair, output int cycles);
        cycles = 0;
        while (cycles < 200) begin
            @(negedge sysclk);
            if (!ctrl.mv_amp_disable[pair])
                break;
            cycles++;
        end
    endtask

    task automatic open_test(input string name);
        test_name     = name;
        errs_at_start = errors;
    endtask

    task automatic close_test();
        @(posedge sysclk);   // last compare has landed
        tests++;
        $display("test %s: %0d errors", test_name, errors - errs_at_start);
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic reset_state_test();
        open_test("reset");
        @(negedge sysclk);
        check_rdata("rdata after reset", 32'd0, reg_rdata);
        check_ctrl("ctrl after reset", model_ctrl(3'b000, 2'b11), ctrl);
        read_expect(REG_VERSION);
        read_expect(REG_STATUS);
        read_expect(REG_WDOG);
        close_test();
    endtask

    task automatic status_mask_test();
        logic [3:0]  pr;
        logic [2:0]  pulses;
        logic [31:0] w;
        open_test("masks");
        for (int i = 0; i < 16; i++) begin
            pr     = 4'(i);
            pulses = 3'(i + 3);   // walk the pulse bits too
            if (pr[1])
                m_relay = pr[0];
            if (pr[3])
                m_pwr = {2{pr[2]}};
            host_write(ADDR_MAIN, 4'd0, REG_STATUS, cmd_word(pulses, pr));
            @(negedge sysclk);
            check_ctrl("after write", model_ctrl(pulses, 2'b11), ctrl);
            @(negedge sysclk);
            check_ctrl("pulse gone", model_ctrl(3'b000, 2'b11), ctrl);
        end
        // would switch power and relay off if it were taken
        w = cmd_word(3'b111, 4'b1010);
        host_write(4'h1, 4'd0, REG_STATUS, w);
        @(negedge sysclk);
        check_ctrl("other space", model_ctrl(3'b000, 2'b11), ctrl);
        host_write(ADDR_MAIN, 4'h2, REG_STATUS, w);
        @(negedge sysclk);
        check_ctrl("nonzero block", model_ctrl(3'b000, 2'b11), ctrl);
        close_test();
    endtask

    task automatic read_mux_test();
        logic [159:0] rnd;
        open_test("read mux");
        for (int s = 0; s < 6; s++) begin
            rnd = {lcg_next(), lcg_next(), lcg_next(), lcg_next(), lcg_next()};
            @(posedge sysclk);
            board_in <= rnd[$bits(board_in_t)-1:0];
            for (int off = 0; off < 16; off++)
                read_expect(4'(off));   // unused offsets too
        end
        close_test();
    endtask

    task automatic settle_delay_test();
        int cycles;
        open_test("settle");
        @(posedge sysclk);
        board_in.mv_good <= 2'b00;
        repeat (3) @(posedge sysclk);   // both counters cleared
        for (int p = 0; p < 2; p++) begin
            @(posedge sysclk);
            board_in.mv_good[p] <= 1'b1;
            settle_length(p, cycles);
            check_rdata("cycles after rise", 32'(SETTLE), cycles);
            check_flag("other pair", p == 0, ctrl.mv_amp_disable[1-p]);
            @(posedge sysclk);
            board_in.mv_good[p] <= 1'b0;   // one-cycle glitch
            @(posedge sysclk);
            board_in.mv_good[p] <= 1'b1;
            settle_length(p, cycles);
            check_rdata("cycles after glitch", 32'(SETTLE), cycles);
        end
        close_test();
    endtask

    task automatic watchdog_test();
        logic [1:0] pwr_before;
        open_test("watchdog");
        pwr_before = m_pwr;
        @(posedge sysclk);
        reg_raddr <= '{space: ADDR_MAIN, chan: 4'd0, block: 4'd0, offset: REG_STATUS};
        m_period = 16'd3;
        host_write(ADDR_MAIN, 4'd0, REG_WDOG, 32'h5a5a_0003);   // upper half ignored
        // host goes quiet, status sampled on every edge
        for (int j = 1; j <= WDOG_TICKS + 4; j++) begin
            @(posedge sysclk);
            m_timeout = (j > WDOG_TICKS);
            m_pwr     = (j > WDOG_TICKS + 1) ? 2'b00 : pwr_before;
            exp_q.push_back(expected_read(REG_STATUS, board_in, m_relay, m_pwr,
                                          m_timeout, m_period));
        end
        @(negedge sysclk);
        check_ctrl("power dropped", model_ctrl(3'b000, 2'b00), ctrl);   // pairs settled
        // power-on write clears the flag
        m_timeout = 1'b0;
        m_pwr     = 2'b11;
        host_write(ADDR_MAIN, 4'd0, REG_STATUS, cmd_word(3'b000, 4'b1100));
        @(negedge sysclk);
        check_ctrl("power back", model_ctrl(3'b000, 2'b00), ctrl);
        read_expect(REG_WDOG);
        read_expect(REG_STATUS);
        m_period = 16'd0;   // disabled from here on
        host_write(ADDR_MAIN, 4'd0, REG_WDOG, 32'd0);
        repeat (4 * WDOG_TICKS) @(posedge sysclk);
        read_expect(REG_STATUS);
        read_expect(REG_WDOG);
        @(negedge sysclk);
        check_flag("power held", 1'b1, &ctrl.pwr_enable);
        close_test();
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        reset     = 1'b1;
        host_wr   = '0;
        reg_raddr = '0;
        board_in  = '0;
        m_relay   = 1'b0;
        m_pwr     = 2'b00;
        m_timeout = 1'b0;
        m_period  = 16'd0;
        repeat (8) @(posedge sysclk);
        reset <= 1'b0;
        reset_state_test();
        status_mask_test();
        read_mux_test();
        settle_delay_test();
        watchdog_test();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // run limit
    initial begin
        repeat (RUN_CYCLES) @(posedge sysclk);
        $display("timeout: run still going after %0d cycles", RUN_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* src/board_ctrl_top.sv */
// ------------------------------
// board control top: register file, settle timers, watchdog
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module board_ctrl_top #(
    parameter logic [3:0]  NUM_CHAN      = 4'd8,
    parameter logic [31:0] VERSION       = 32'h44514c41,   // "DQLA"
    parameter logic [23:0] SETTLE_CYCLES = 24'd1966080,    // about 40 ms
    parameter int unsigned WDOG_SHIFT    = 8
) (
    input  wire logic                  sysclk,
    input  wire logic                  reset,
    input  wire board_pkg::host_wr_t   host_wr,
    input  wire board_pkg::reg_addr_t  reg_raddr,
    input  wire board_pkg::board_in_t  board_in,
    output logic [31:0]                reg_rdata,
    output board_pkg::board_ctrl_t     ctrl
);

    logic        pwr_enable_cmd;    // status write with power on
    logic        wdog_timeout;
    logic [15:0] wdog_period;
    logic [1:0]  mv_amp_disable;    // one bit per amplifier pair

    board_regs #(
        .NUM_CHAN (NUM_CHAN),
        .VERSION  (VERSION)
    ) board_regs_i (
        .sysclk         (sysclk),
        .reset          (reset),
        .host_wr        (host_wr),
        .reg_raddr      (reg_raddr),
        .board_in       (board_in),
        .mv_amp_disable (mv_amp_disable),
        .wdog_timeout   (wdog_timeout),
        .wdog_period    (wdog_period),
        .pwr_enable_cmd (pwr_enable_cmd),
        .ctrl           (ctrl),
        .reg_rdata      (reg_rdata)
    );

    // ------------------------------
    // one settle timer per pair
    // ------------------------------
    for (genvar p = 0; p < 2; p++) begin : g_mv_settle
        mv_settle_timer #(
            .SETTLE_CYCLES (SETTLE_CYCLES)
        ) mv_settle_timer_i (
            .sysclk      (sysclk),
            .reset       (reset),
            .mv_good     (board_in.mv_good[p]),
            .amp_disable (mv_amp_disable[p])
        );
    end

    host_watchdog #(
        .WDOG_SHIFT (WDOG_SHIFT)
    ) host_watchdog_i (
        .sysclk         (sysclk),
        .reset          (reset),
        .host_wr        (host_wr),
        .pwr_enable_cmd (pwr_enable_cmd),
        .wdog_timeout   (wdog_timeout),
        .wdog_period    (wdog_period)
    );

endmodule

`default_nettype wire

/* src/host_watchdog.sv */
// ------------------------------
// host watchdog: period register, prescaled idle counter,
// sticky timeout flag
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module host_watchdog #(
    parameter int unsigned WDOG_SHIFT = 8     // prescale, 2^shift clocks per period tick
) (
    input  wire logic                 sysclk,
    input  wire logic                 reset,
    input  wire board_pkg::host_wr_t  host_wr,
    input  wire logic                 pwr_enable_cmd,   // clears the timeout
    output logic                      wdog_timeout,
    output logic [15:0]               wdog_period       // 0 disables the watchdog
);
    import board_pkg::*;

    localparam int unsigned CNT_W = 16 + WDOG_SHIFT;

    logic             write_main;
    logic [CNT_W-1:0] idle_count;    // clocks since last host write
    logic [CNT_W-1:0] limit;         // period in clocks
    logic             wdog_on;

    assign write_main = is_main_write(host_wr);
    assign wdog_on    = (wdog_period != 16'd0);
    assign limit      = CNT_W'(wdog_period) << WDOG_SHIFT;

    // ------------------------------
    // period register
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (reset)
            wdog_period <= 16'd0;
        else if (write_main && (host_wr.addr.offset == REG_WDOG))
            wdog_period <= host_wr.data.raw[15:0];   // low half of the raw word
    end

    // ------------------------------
    // idle counter
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            idle_count <= '0;
        end else if (write_main || !wdog_on) begin
            idle_count <= '0;                  // host is alive, start over
        end else if (idle_count < limit) begin
            idle_count <= idle_count + 1'b1;   // stops at the limit
        end
    end

    // sticky flag, set on the edge the count reaches the limit
    always_ff @(posedge sysclk) begin
        if (reset)
            wdog_timeout <= 1'b0;
        else if (pwr_enable_cmd)
            wdog_timeout <= 1'b0;
        else if (wdog_on && !write_main && (idle_count == limit - 1'b1))
            wdog_timeout <= 1'b1;
    end

endmodule

`default_nettype wire

/* src/mv_settle_timer.sv */
// ------------------------------
// motor voltage settle timer for one amplifier pair
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module mv_settle_timer #(
    parameter logic [23:0] SETTLE_CYCLES = 24'd1966080   // 7680 x 256 clocks
) (
    input  wire logic sysclk,
    input  wire logic reset,
    input  wire logic mv_good,      // motor supply present
    output logic      amp_disable   // hold amplifiers off
);

    // count value seen on the edge that ends the delay
    localparam logic [23:0] LAST = SETTLE_CYCLES - 24'd1;

    logic [23:0] settle_count;

    // ------------------------------
    // delay after supply comes up
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            settle_count <= 24'd0;
            amp_disable  <= 1'b1;              // amps off out of reset
        end else if (!mv_good) begin
            // any drop restarts the whole delay
            settle_count <= 24'd0;
            amp_disable  <= 1'b1;
        end else if (settle_count != SETTLE_CYCLES) begin
            settle_count <= settle_count + 24'd1;
            amp_disable  <= (settle_count != LAST);   // release on the final count
        end
        // once settled, counter parks and amps stay enabled
    end

endmodule

`default_nettype wire

/* src/board_regs.sv */
// ------------------------------
// board register file: status command decode, control
// outputs, reset pulses and registered read mux
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module board_regs #(
    parameter logic [3:0]  NUM_CHAN = 4'd8,
    parameter logic [31:0] VERSION  = 32'h44514c41   // "DQLA"
) (
    input  wire logic                   sysclk,
    input  wire logic                   reset,
    input  wire board_pkg::host_wr_t    host_wr,         // write strobe, address, data
    input  wire board_pkg::reg_addr_t   reg_raddr,       // held read address
    input  wire board_pkg::board_in_t   board_in,
    input  wire logic [1:0]             mv_amp_disable,  // from settle timers
    input  wire logic                   wdog_timeout,
    input  wire logic [15:0]            wdog_period,
    output logic                        pwr_enable_cmd,  // host asks for power on
    output board_pkg::board_ctrl_t      ctrl,
    output logic [31:0]                 reg_rdata
);
    import board_pkg::*;

    logic        write_main;      // write to board block
    logic        write_status;    // write to status register
    status_cmd_t cmd;             // command view of write data

    logic [1:0]  pwr_enable;
    logic        relay_on;
    logic        dout_cfg_reset;
    logic        ioexp_cfg_reset;
    logic        dac_test_reset;

    logic [31:0] reg_status;
    logic [31:0] reg_digin;

    // ------------------------------
    // write decode
    // ------------------------------
    assign write_main   = is_main_write(host_wr);
    assign write_status = write_main && (host_wr.addr.offset == REG_STATUS);
    assign cmd          = host_wr.data.cmd;

    // power-on request also clears the watchdog flag
    assign pwr_enable_cmd = write_status && cmd.pwr_mask && cmd.pwr_val;

    // relay and power state, each bit written only where its mask is set
    always_ff @(posedge sysclk) begin
        if (reset) begin
            relay_on   <= 1'b0;
            pwr_enable <= 2'b00;
        end else begin
            if (write_status && cmd.relay_mask)
                relay_on <= cmd.relay_val;
            // timeout drops power unless the host re-enables this cycle
            if (wdog_timeout && !pwr_enable_cmd)
                pwr_enable <= 2'b00;
            else if (write_status && cmd.pwr_mask)
                pwr_enable <= {2{cmd.pwr_val}};
        end
    end

    // reset pulses, high for one cycle after the command
    always_ff @(posedge sysclk) begin
        if (reset) begin
            dout_cfg_reset  <= 1'b0;
            ioexp_cfg_reset <= 1'b0;
            dac_test_reset  <= 1'b0;
        end else if (write_status) begin
            dout_cfg_reset  <= cmd.dout_cfg_reset;   // re-check dout config
            ioexp_cfg_reset <= cmd.ioexp_cfg_reset;  // redetect io expander
            dac_test_reset  <= cmd.dac_test_reset;   // rerun dac type test
        end else begin
            dout_cfg_reset  <= 1'b0;
            ioexp_cfg_reset <= 1'b0;
            dac_test_reset  <= 1'b0;
        end
    end

    assign ctrl = board_ctrl_t'{
        pwr_enable:      pwr_enable,
        relay_on:        relay_on,
        dout_cfg_reset:  dout_cfg_reset,
        dac_test_reset:  dac_test_reset,
        ioexp_cfg_reset: ioexp_cfg_reset,
        mv_amp_disable:  mv_amp_disable
    };

    // ------------------------------
    // read words
    // ------------------------------
    // software expects board_id in 27:24 and wdog_timeout in bit 23
    assign reg_status = {
        // byte 3
        NUM_CHAN, board_in.board_id,
        // byte 2
        wdog_timeout, board_in.quad_dac, 1'b0,
        &board_in.mv_good,                       // both supplies good
        &pwr_enable, 1'b0, relay_on,
        // byte 1
        board_in.mv_good, 2'b00, board_in.dout_cfg_valid, board_in.dout_cfg_bidir,
        // byte 0, dout bit 31 flags a running waveform
        board_in.safety_fb, board_in.mv_fb, board_in.dout[31], 1'b0,
        board_in.ioexp_present
    };

    assign reg_digin = {board_in.dout[7:0], board_in.neg_limit,
                        board_in.pos_limit, board_in.home};

    // read mux, holds its value during a write cycle
    always_ff @(posedge sysclk) begin
        if (reset) begin
            reg_rdata <= 32'd0;
        end else if (!write_main) begin
            case (reg_raddr.offset)
                REG_STATUS:  reg_rdata <= reg_status;
                REG_VERSION: reg_rdata <= VERSION;
                REG_TEMPSNS: reg_rdata <= board_in.temp_sense;
                REG_DIGIOUT: reg_rdata <= board_in.dout;
                REG_DSSTAT:  reg_rdata <= board_in.ds_status;
                REG_DIGIN:   reg_rdata <= reg_digin;
                REG_WDOG:    reg_rdata <= {16'd0, wdog_period};
                default:     reg_rdata <= 32'd0;   // unmapped offsets
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/board_pkg.sv */
// ------------------------------
// board control package: address map, register offsets,
// host bus and board structs, write-data union
// ------------------------------
`default_nettype none

package board_pkg;

    // ------------------------------
    // address map
    // ------------------------------
    localparam logic [3:0] ADDR_MAIN   = 4'h0;   // board register space

    localparam logic [3:0] REG_STATUS  = 4'h0;   // status / command word
    localparam logic [3:0] REG_WDOG    = 4'h3;   // watchdog period
    localparam logic [3:0] REG_VERSION = 4'h4;   // firmware version
    localparam logic [3:0] REG_TEMPSNS = 4'h5;   // temperature sensor
    localparam logic [3:0] REG_DIGIOUT = 4'h6;   // digital outputs
    localparam logic [3:0] REG_DIGIN   = 4'ha;   // limits and home
    localparam logic [3:0] REG_DSSTAT  = 4'hd;   // dallas chip status

    // host register address, top nibble first
    typedef struct packed {
        logic [3:0] space;
        logic [3:0] chan;
        logic [3:0] block;   // must be zero for board regs
        logic [3:0] offset;
    } reg_addr_t;

    // status register command bits, as written by the host
    typedef struct packed {
        logic [6:0]  upper;
        logic        dout_cfg_reset;    // bit 24
        logic        ioexp_cfg_reset;   // bit 23
        logic        dac_test_reset;    // bit 22
        logic [1:0]  reboot;            // handled elsewhere
        logic        pwr_mask;          // bit 19
        logic        pwr_val;
        logic        relay_mask;        // bit 17
        logic        relay_val;
        logic [15:0] lower;
    } status_cmd_t;

    // write word: status command or plain number
    typedef union packed {
        status_cmd_t cmd;
        logic [31:0] raw;
    } host_wdata_u;

    typedef struct packed {
        logic        strobe;   // one cycle per write
        reg_addr_t   addr;
        host_wdata_u data;
    } host_wr_t;

    // sense inputs from the board
    typedef struct packed {
        logic [31:0] dout;
        logic [7:0]  neg_limit;
        logic [7:0]  pos_limit;
        logic [7:0]  home;
        logic [1:0]  mv_good;
        logic [1:0]  safety_fb;
        logic [1:0]  mv_fb;
        logic [3:0]  board_id;
        logic [31:0] temp_sense;
        logic [31:0] ds_status;
        logic [1:0]  dout_cfg_valid;
        logic [1:0]  dout_cfg_bidir;
        logic [1:0]  quad_dac;
        logic [1:0]  ioexp_present;
    } board_in_t;

    // control outputs to the board
    typedef struct packed {
        logic [1:0] pwr_enable;
        logic       relay_on;
        logic       dout_cfg_reset;
        logic       dac_test_reset;
        logic       ioexp_cfg_reset;
        logic [1:0] mv_amp_disable;
    } board_ctrl_t;

    // write to the board register block of the main space
    function automatic logic is_main_write(host_wr_t wr);
        return wr.strobe && (wr.addr.space == ADDR_MAIN) && (wr.addr.block == 4'd0);
    endfunction

endpackage

`default_nettype wire
